// File: design/blk_pkg.sv
package blk_pkg;

    // one pixel word, 8 bits each of three components
    localparam int pixel_w = 24;

    // block geometry
    localparam int blk_dim = 8;
    localparam int blk_pix = 64;

    // one bank holds a strip of up to 32 block columns, 256 pixels wide
    localparam int max_blk_cols = 32;
    localparam int col_w = 5;

    // pixel dimensions and pixel counters
    localparam int dim_w = 12;

    // strip buffer address, built from fields and used flat by the memory
    typedef union packed {
        logic [11:0] raw;
        struct packed {
            logic             bank;
            logic [col_w-1:0] block_col;
            logic [2:0]       row;
            logic [2:0]       col;
        } fields;
    } strip_addr_t;

endpackage

// File: design/frame_geometry.sv
`timescale 1ns/1ns

module frame_geometry (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      frame_done,
    input  logic [blk_pkg::dim_w-1:0] frame_width,
    input  logic [blk_pkg::dim_w-1:0] frame_height,
    output logic [blk_pkg::dim_w-1:0] width,
    output logic [blk_pkg::dim_w-1:0] height,
    output logic [blk_pkg::col_w-1:0] blk_cols,
    output logic [8:0]                blk_rows,
    output logic                      frame_start
);

    logic frame_done_d;
    logic done_rise;
    logic done_fall;

    assign done_rise = frame_done && !frame_done_d;
    assign done_fall = !frame_done && frame_done_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frame_done_d <= 1'b0;
            frame_start  <= 1'b0;
        end else begin
            frame_done_d <= frame_done;
            frame_start  <= done_fall;
        end
    end

    // dimensions are taken on the rising edge only
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            width    <= '0;
            height   <= '0;
            blk_cols <= '0;
            blk_rows <= '0;
        end else if (done_rise) begin
            width    <= frame_width;
            height   <= frame_height;
            blk_cols <= blk_pkg::col_w'(frame_width / blk_pkg::blk_dim);
            blk_rows <= 9'(frame_height / blk_pkg::blk_dim);
        end
    end

endmodule

// File: design/strip_writer.sv
`timescale 1ns/1ns

module strip_writer #(
    parameter int max_blk_cols = blk_pkg::max_blk_cols
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        frame_start,
    input  logic [blk_pkg::dim_w-1:0]   width,
    input  logic [blk_pkg::dim_w-1:0]   height,
    input  logic                        burst_ready,
    input  logic                        wr_valid,
    input  logic [31:0]                 wr_data,
    input  logic                        wr_last,
    input  logic                        rd_bank,
    output logic                        burst_valid,
    output logic                        wr_ready,
    output logic                        ram_we,
    output blk_pkg::strip_addr_t        ram_waddr,
    output logic [blk_pkg::pixel_w-1:0] ram_wdata,
    output logic                        wr_bank,
    output logic [blk_pkg::col_w-1:0]   wr_done_col,
    output logic [8:0]                  wr_strip
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_burst = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;

    logic [1:0]                state;
    logic [1:0]                state_nxt;
    logic [blk_pkg::dim_w-1:0] x_cnt;
    logic [blk_pkg::dim_w-1:0] y_cnt;
    logic                      ahead;
    logic                      line_end;
    logic                      strip_end;
    logic                      frame_end;
    logic                      almost_full;
    logic                      full;
    logic                      xfer;

    // writer is one strip ahead of the reader
    assign ahead     = wr_bank != rd_bank;
    assign line_end  = x_cnt == width - 1'b1;
    assign strip_end = line_end && (y_cnt[2:0] == 3'd7);
    assign frame_end = line_end && (y_cnt == height - 1'b1);

    // no new burst this late in a strip while the other bank is busy
    assign almost_full = ahead && (y_cnt[2:0] >= 3'd5);
    // last pixel of the strip must wait for the reader to release its bank
    assign full        = ahead && strip_end;

    assign burst_valid = (state == st_burst) && !almost_full;
    assign wr_ready    = (state == st_data) && !full;
    assign xfer        = wr_valid && wr_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (frame_start)
                    state_nxt = st_burst;
            end
            st_burst: begin
                if (burst_valid && burst_ready)
                    state_nxt = st_data;
            end
            st_data: begin
                if (xfer && frame_end)
                    state_nxt = st_idle;
                else if (xfer && wr_last)
                    state_nxt = st_burst;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    // raster position of the next incoming pixel
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (frame_start) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (xfer) begin
            if (line_end) begin
                x_cnt <= '0;
                if (y_cnt == height - 1'b1)
                    y_cnt <= '0;
                else
                    y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            wr_bank <= 1'b0;
        else if (xfer && strip_end)
            wr_bank <= !wr_bank;
    end

    always_comb begin
        ram_waddr.fields.bank      = wr_bank;
        ram_waddr.fields.block_col = x_cnt[blk_pkg::col_w+2:3];
        ram_waddr.fields.row       = y_cnt[2:0];
        ram_waddr.fields.col       = x_cnt[2:0];
    end

    assign ram_we    = xfer;
    assign ram_wdata = wr_data[blk_pkg::pixel_w-1:0];

    // blocks left of this column are complete once line 7 is under way
    assign wr_done_col = (y_cnt[2:0] == 3'd7) ? x_cnt[blk_pkg::col_w+2:3] : '0;
    assign wr_strip    = y_cnt[blk_pkg::dim_w-1:3];

    burst_hold: assert property (@(posedge clk) disable iff (!rstn)
        burst_valid && !burst_ready |=> burst_valid);

    width_fits: assert property (@(posedge clk) disable iff (!rstn)
        frame_start |-> int'(width) <= max_blk_cols * blk_pkg::blk_dim);

endmodule

// File: design/strip_ram.sv
`timescale 1ns/1ns

module strip_ram #(
    parameter int max_blk_cols = blk_pkg::max_blk_cols
) (
    input  logic                        clk,
    input  logic                        we,
    input  blk_pkg::strip_addr_t        waddr,
    input  logic [blk_pkg::pixel_w-1:0] wdata,
    input  blk_pkg::strip_addr_t        raddr,
    output logic [blk_pkg::pixel_w-1:0] rdata
);

    // two banks, each one strip of eight lines
    localparam int depth = 2 * max_blk_cols * blk_pkg::blk_pix;

    logic [blk_pkg::pixel_w-1:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr.raw] <= wdata;
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr.raw];
    end

endmodule

// File: design/block_reader.sv
`timescale 1ns/1ns

module block_reader #(
    parameter int gap_cycles = 13
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        frame_start,
    input  logic [blk_pkg::col_w-1:0]   blk_cols,
    input  logic [8:0]                  blk_rows,
    input  logic                        wr_bank,
    input  logic [blk_pkg::col_w-1:0]   wr_done_col,
    input  logic [8:0]                  wr_strip,
    input  logic                        out_hold,
    input  logic [blk_pkg::pixel_w-1:0] rdata,
    output blk_pkg::strip_addr_t        ram_raddr,
    output logic                        rd_bank,
    output logic                        pix_valid,
    output logic [blk_pkg::pixel_w-1:0] pix_data,
    output logic                        blk_first,
    output logic                        blk_last,
    output logic                        frame_last
);

    localparam int gap_w = $clog2(gap_cycles + 1);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_wait = 2'd1;
    localparam logic [1:0] st_read = 2'd2;
    localparam logic [1:0] st_gap  = 2'd3;

    logic [1:0]                state;
    logic [1:0]                state_nxt;
    logic [5:0]                pix_cnt;
    logic [blk_pkg::col_w-1:0] col_cnt;
    logic [8:0]                strip_cnt;
    logic [gap_w-1:0]          gap_cnt;
    logic                      rd_en;
    logic                      blk_end;
    logic                      last_col;
    logic                      last_strip;
    logic                      gap_done;
    logic                      blk_written;

    assign rd_en      = state == st_read;
    assign blk_end    = rd_en && (pix_cnt == 6'(blk_pkg::blk_pix - 1));
    // a 32 column strip wraps blk_cols to zero, minus one still lands on 31
    assign last_col   = col_cnt == blk_cols - 1'b1;
    assign last_strip = strip_cnt == blk_rows - 1'b1;
    assign gap_done   = gap_cnt == gap_w'(gap_cycles - 1);

    // whole strip done when the writer moved on, else check line 7 progress
    assign blk_written = (wr_bank != rd_bank) ||
                         ((wr_strip == strip_cnt) && (col_cnt < wr_done_col));

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (frame_start)
                    state_nxt = st_wait;
            end
            st_wait: begin
                // hold only matters between blocks
                if (!out_hold && blk_written)
                    state_nxt = st_read;
            end
            st_read: begin
                if (blk_end)
                    state_nxt = st_gap;
            end
            st_gap: begin
                if (gap_done)
                    state_nxt = (strip_cnt == blk_rows) ? st_idle : st_wait;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    // position inside the frame, in blocks and in pixels of a block
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_cnt   <= '0;
            col_cnt   <= '0;
            strip_cnt <= '0;
        end else if (frame_start) begin
            pix_cnt   <= '0;
            col_cnt   <= '0;
            strip_cnt <= '0;
        end else if (rd_en) begin
            pix_cnt <= pix_cnt + 1'b1;
            if (blk_end) begin
                if (last_col) begin
                    col_cnt   <= '0;
                    strip_cnt <= strip_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            rd_bank <= 1'b0;
        else if (blk_end && last_col)
            rd_bank <= !rd_bank;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            gap_cnt <= '0;
        else if (state == st_gap)
            gap_cnt <= gap_cnt + 1'b1;
        else
            gap_cnt <= '0;
    end

    always_comb begin
        ram_raddr.fields.bank      = rd_bank;
        ram_raddr.fields.block_col = col_cnt;
        ram_raddr.fields.row       = pix_cnt[5:3];
        ram_raddr.fields.col       = pix_cnt[2:0];
    end

    // flags follow the ram read latency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_valid  <= 1'b0;
            blk_first  <= 1'b0;
            blk_last   <= 1'b0;
            frame_last <= 1'b0;
        end else begin
            pix_valid  <= rd_en;
            blk_first  <= rd_en && (pix_cnt == '0);
            blk_last   <= blk_end;
            frame_last <= blk_end && last_col && last_strip;
        end
    end

    assign pix_data = rdata;

    gap_quiet: assert property (@(posedge clk) disable iff (!rstn)
        blk_last |=> !pix_valid [*gap_cycles]);

    read_written: assert property (@(posedge clk) disable iff (!rstn)
        rd_en |-> blk_written);

endmodule

// File: design/raster_to_block.sv
`timescale 1ns/1ns

module raster_to_block #(
    parameter int gap_cycles   = 13,
    parameter int max_blk_cols = blk_pkg::max_blk_cols
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        frame_done,
    input  logic [blk_pkg::dim_w-1:0]   frame_width,
    input  logic [blk_pkg::dim_w-1:0]   frame_height,
    output logic                        burst_valid,
    input  logic                        burst_ready,
    input  logic                        wr_valid,
    input  logic [31:0]                 wr_data,
    input  logic                        wr_last,
    output logic                        wr_ready,
    output logic                        pix_valid,
    output logic [blk_pkg::pixel_w-1:0] pix_data,
    output logic                        blk_first,
    output logic                        blk_last,
    output logic                        frame_last,
    input  logic                        out_hold
);

    logic [blk_pkg::dim_w-1:0]   width;
    logic [blk_pkg::dim_w-1:0]   height;
    logic [blk_pkg::col_w-1:0]   blk_cols;
    logic [8:0]                  blk_rows;
    logic                        frame_start;
    logic                        ram_we;
    blk_pkg::strip_addr_t        ram_waddr;
    logic [blk_pkg::pixel_w-1:0] ram_wdata;
    blk_pkg::strip_addr_t        ram_raddr;
    logic [blk_pkg::pixel_w-1:0] ram_rdata;
    logic                        wr_bank;
    logic                        rd_bank;
    logic [blk_pkg::col_w-1:0]   wr_done_col;
    logic [8:0]                  wr_strip;

    frame_geometry u_frame_geometry (
        .clk          (clk),
        .rstn         (rstn),
        .frame_done   (frame_done),
        .frame_width  (frame_width),
        .frame_height (frame_height),
        .width        (width),
        .height       (height),
        .blk_cols     (blk_cols),
        .blk_rows     (blk_rows),
        .frame_start  (frame_start)
    );

    strip_writer #(
        .max_blk_cols (max_blk_cols)
    ) u_strip_writer (
        .clk          (clk),
        .rstn         (rstn),
        .frame_start  (frame_start),
        .width        (width),
        .height       (height),
        .burst_ready  (burst_ready),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .wr_last      (wr_last),
        .rd_bank      (rd_bank),
        .burst_valid  (burst_valid),
        .wr_ready     (wr_ready),
        .ram_we       (ram_we),
        .ram_waddr    (ram_waddr),
        .ram_wdata    (ram_wdata),
        .wr_bank      (wr_bank),
        .wr_done_col  (wr_done_col),
        .wr_strip     (wr_strip)
    );

    strip_ram #(
        .max_blk_cols (max_blk_cols)
    ) u_strip_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    block_reader #(
        .gap_cycles (gap_cycles)
    ) u_block_reader (
        .clk          (clk),
        .rstn         (rstn),
        .frame_start  (frame_start),
        .blk_cols     (blk_cols),
        .blk_rows     (blk_rows),
        .wr_bank      (wr_bank),
        .wr_done_col  (wr_done_col),
        .wr_strip     (wr_strip),
        .out_hold     (out_hold),
        .rdata        (ram_rdata),
        .ram_raddr    (ram_raddr),
        .rd_bank      (rd_bank),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .blk_first    (blk_first),
        .blk_last     (blk_last),
        .frame_last   (frame_last)
    );

endmodule

// File: verification/tb_ref_model.svh
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// fixed seed for every random stream of the testbench
localparam logic [31:0] rng_seed = 32'd7606;

// pixels of the frame being sent, in raster order
logic [blk_pkg::pixel_w-1:0] frame_mem [0:4095];
logic [31:0]                 pix_state = rng_seed;
int                          cur_w;
int                          frame_pixels;

// 32 bit xorshift, returns the next state
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] t;
    t = s;
    t = t ^ (t << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
endfunction

// new random picture for a frame of w by h pixels
task automatic fill_frame_store(input int w, input int h);
    int i;
    cur_w        = w;
    frame_pixels = w * h;
    for (i = 0; i < frame_pixels; i++) begin
        pix_state    = xorshift(pix_state);
        frame_mem[i] = pix_state[blk_pkg::pixel_w-1:0];
    end
endtask

// expected output k of the frame, packed as {frame_last, blk_last, blk_first, pixel}
// order is strip, block column, row in block, column in block
function automatic logic [blk_pkg::pixel_w+2:0] ref_output(input int k);
    int   per_strip;
    int   strip;
    int   bcol;
    int   p;
    int   x;
    int   y;
    logic first;
    logic last;
    logic flast;
    per_strip = (cur_w / blk_pkg::blk_dim) * blk_pkg::blk_pix;
    strip     = k / per_strip;
    bcol      = (k % per_strip) / blk_pkg::blk_pix;
    p         = k % blk_pkg::blk_pix;
    x         = bcol * blk_pkg::blk_dim + p % blk_pkg::blk_dim;
    y         = strip * blk_pkg::blk_dim + p / blk_pkg::blk_dim;
    first     = p == 0;
    last      = p == blk_pkg::blk_pix - 1;
    flast     = k == frame_pixels - 1;
    return {flast, last, first, frame_mem[y * cur_w + x]};
endfunction

`endif

// File: verification/tb_raster_to_block.sv
`timescale 1ns/1ns

module tb_raster_to_block;

    localparam int gap_cycles = 13;
    // two frames of 2048 pixels in all and a long hold need a few thousand cycles
    localparam int timeout_cycles   = 40000;
    localparam int long_hold_cycles = 800;

    logic                        clk;
    logic                        rstn;
    logic                        frame_done;
    logic [blk_pkg::dim_w-1:0]   frame_width;
    logic [blk_pkg::dim_w-1:0]   frame_height;
    logic                        burst_valid;
    logic                        burst_ready;
    logic                        wr_valid;
    logic [31:0]                 wr_data;
    logic                        wr_last;
    logic                        wr_ready;
    logic                        pix_valid;
    logic [blk_pkg::pixel_w-1:0] pix_data;
    logic                        blk_first;
    logic                        blk_last;
    logic                        frame_last;
    logic                        out_hold;

    `include "tb_ref_model.svh"

    logic [31:0] src_state  = rng_seed ^ 32'h0000_5a5a;
    logic [31:0] hold_state = rng_seed ^ 32'h00a5_0000;
    logic        hold_force = 1'b0;
    logic        hold_d1 = 1'b0;
    logic        hold_d2 = 1'b0;
    logic        prev_valid = 1'b0;
    logic        req_waiting = 1'b0;
    int          out_idx = 0;
    int          blk_cnt = 0;
    int          idle_cnt = gap_cycles;
    int          sent_cnt = 0;
    int          cycle_cnt = 0;

    raster_to_block #(
        .gap_cycles (gap_cycles)
    ) u_raster_to_block (
        .clk          (clk),
        .rstn         (rstn),
        .frame_done   (frame_done),
        .frame_width  (frame_width),
        .frame_height (frame_height),
        .burst_valid  (burst_valid),
        .burst_ready  (burst_ready),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .wr_last      (wr_last),
        .wr_ready     (wr_ready),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .blk_first    (blk_first),
        .blk_last     (blk_last),
        .frame_last   (frame_last),
        .out_hold     (out_hold)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_idle_outputs();
        assert (!burst_valid && !wr_ready && !pix_valid && !blk_first && !blk_last && !frame_last)
        else fail_run($sformatf(
            "Error {burst_valid,wr_ready,pix_valid,blk_first,blk_last,frame_last} exp 00 got %h",
            {burst_valid, wr_ready, pix_valid, blk_first, blk_last, frame_last}));
    endtask

    task automatic start_frame(input int w, input int h);
        fill_frame_store(w, h);
        out_idx = 0;
        @(negedge clk);
        frame_width  = w;
        frame_height = h;
        frame_done   = 1'b1;
        repeat (3) @(negedge clk);
        frame_done = 1'b0;
    endtask

    // bursts of random length, wr_valid with random gaps
    task automatic send_frame();
        int          left;
        logic        in_burst;
        logic        taken;
        logic [31:0] r;
        left     = 0;
        in_burst = 1'b0;
        taken    = 1'b0;
        sent_cnt = 0;
        while (sent_cnt < frame_pixels) begin
            @(negedge clk);
            src_state   = xorshift(src_state);
            r           = src_state;
            burst_ready = 1'b0;
            if (!in_burst) begin
                wr_valid    = 1'b0;
                wr_last     = 1'b0;
                taken       = 1'b0;
                burst_ready = r[0];
                if (burst_valid && burst_ready) begin
                    in_burst = 1'b1;
                    left     = 1 + int'(r[8:4]);
                    if (left > frame_pixels - sent_cnt)
                        left = frame_pixels - sent_cnt;
                end
            end else begin
                // an offered word stays on the bus until taken
                if (!wr_valid || taken) begin
                    wr_valid = r[2:1] != 2'b00;
                    wr_data  = {r[31:24], frame_mem[sent_cnt]};
                end
                wr_last = left == 1;
                taken   = wr_valid && wr_ready;
                if (taken) begin
                    sent_cnt++;
                    left--;
                    if (left == 0)
                        in_burst = 1'b0;
                end
            end
        end
        @(negedge clk);
        wr_valid    = 1'b0;
        wr_last     = 1'b0;
        burst_ready = 1'b0;
    endtask

    // long out_hold after the first block, the writer has to stall
    task automatic apply_long_hold();
        int mark;
        while (blk_cnt < 1)
            @(negedge clk);
        @(posedge clk);
        hold_force = 1'b1;
        repeat (long_hold_cycles - 200) @(posedge clk);
        mark = sent_cnt;
        repeat (200) @(posedge clk);
        assert (sent_cnt == mark && sent_cnt < frame_pixels)
        else fail_run("writer kept accepting pixels while the output was held for a long time");
        hold_force = 1'b0;
    endtask

    task automatic wait_frame_out();
        while (out_idx < frame_pixels)
            @(negedge clk);
        // room for any extra pixel to show up, and for the last gap
        repeat (40) @(negedge clk);
    endtask

    always @(negedge clk) begin
        hold_state = xorshift(hold_state);
        out_hold   = hold_force || (rstn && hold_state[1:0] == 2'b00);
    end

    always @(posedge clk) begin : compare_outputs
        logic [blk_pkg::pixel_w+2:0] exp_out;
        if (rstn) begin
            if (pix_valid) begin
                assert (out_idx < frame_pixels)
                else fail_run("a pixel came out after the last pixel of the frame");
                exp_out = ref_output(out_idx);
                if (exp_out[blk_pkg::pixel_w]) begin
                    assert (idle_cnt >= gap_cycles)
                    else fail_run($sformatf("Error idle cycles before block exp >= %h got %h",
                        gap_cycles, idle_cnt));
                    assert (!hold_d2)
                    else fail_run("a block started while out_hold was high");
                end else begin
                    assert (prev_valid)
                    else fail_run("the pixels of a block were not on consecutive cycles");
                end
                assert (pix_data == exp_out[blk_pkg::pixel_w-1:0])
                else fail_run($sformatf("Error pix_data at %0d exp %h got %h",
                    out_idx, exp_out[blk_pkg::pixel_w-1:0], pix_data));
                assert (blk_first == exp_out[blk_pkg::pixel_w])
                else fail_run($sformatf("Error blk_first at %0d exp %h got %h",
                    out_idx, exp_out[blk_pkg::pixel_w], blk_first));
                assert (blk_last == exp_out[blk_pkg::pixel_w+1])
                else fail_run($sformatf("Error blk_last at %0d exp %h got %h",
                    out_idx, exp_out[blk_pkg::pixel_w+1], blk_last));
                assert (frame_last == exp_out[blk_pkg::pixel_w+2])
                else fail_run($sformatf("Error frame_last at %0d exp %h got %h",
                    out_idx, exp_out[blk_pkg::pixel_w+2], frame_last));
                if (exp_out[blk_pkg::pixel_w+1]) begin
                    idle_cnt = 0;
                    blk_cnt++;
                end
                out_idx++;
            end else begin
                assert (!blk_first && !blk_last && !frame_last)
                else fail_run($sformatf("Error {blk_first,blk_last,frame_last} exp 0 got %h",
                    {blk_first, blk_last, frame_last}));
                assert (out_idx % blk_pkg::blk_pix == 0)
                else fail_run("pix_valid dropped in the middle of a block");
                idle_cnt++;
            end
            // a request without a grant must stay up
            if (req_waiting) begin
                assert (burst_valid)
                else fail_run("burst_valid fell before the burst was granted");
            end
            req_waiting = burst_valid && !burst_ready;
            hold_d2     = hold_d1;
            hold_d1     = out_hold;
            prev_valid  = pix_valid;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles)
            fail_run("the run did not finish within the cycle limit");
    end

    initial begin
        rstn         = 1'b0;
        frame_done   = 1'b0;
        frame_width  = '0;
        frame_height = '0;
        burst_ready  = 1'b0;
        wr_valid     = 1'b0;
        wr_data      = '0;
        wr_last      = 1'b0;
        out_hold     = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rstn = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_idle_outputs();
        end

        // two strips, random holds plus one long hold
        start_frame(32, 16);
        fork
            send_frame();
            apply_long_hold();
        join
        wait_frame_out();

        // three strips with new dimensions
        start_frame(64, 24);
        send_frame();
        wait_frame_out();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: sources.f
+incdir+verification
design/blk_pkg.sv
design/frame_geometry.sv
design/strip_writer.sv
design/strip_ram.sv
design/block_reader.sv
design/raster_to_block.sv
verification/tb_raster_to_block.sv
